/* snes_cart_pkg.sv */
/*
 * Shared widths, header byte offsets, default size codes, layout codes
 * and the header word union of the cartridge front end
 */
`default_nettype none

package snes_cart_pkg;

	// =========================================================================
	// Bus widths
	// =========================================================================
	localparam int IOCTL_AW = 25;
	localparam int IOCTL_DW = 16;
	localparam int MASK_W   = 24;
	localparam int LBA_W    = 32;

	// Flags, address, compare and replace, 32 bits each
	localparam int GG_W = 128;

	// Download index reserved for cheat files
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// =========================================================================
	// Cartridge header
	// =========================================================================
	// Copier header in front of the ROM image
	localparam logic [IOCTL_AW-1:0] HDR_SKIP = 25'h200;

	// Info word per layout, RAM size sits 2 bytes further on
	localparam logic [IOCTL_AW-1:0] LOROM_INFO   = 25'h7FD6;
	localparam logic [IOCTL_AW-1:0] HIROM_INFO   = 25'hFFD6;
	localparam logic [IOCTL_AW-1:0] EXHIROM_INFO = 25'h40FFD6;

	localparam logic [3:0] DEF_ROM_SIZE = 4'hC;
	localparam logic [3:0] DEF_RAM_SIZE = 4'h0;

	// Mask is SIZE_UNIT << size code, minus one
	localparam int SIZE_UNIT = 1024;

	// Layout selection from the menu
	localparam logic [2:0] ROM_LAYOUT_AUTO = 3'd0;
	localparam logic [2:0] ROM_LAYOUT_NONE = 3'd1;
	localparam logic [2:0] ROM_LAYOUT_LO   = 3'd2;
	localparam logic [2:0] ROM_LAYOUT_HI   = 3'd3;
	localparam logic [2:0] ROM_LAYOUT_EXHI = 3'd4;

	// One backup RAM sector is 512 bytes
	localparam int SECTOR_SHIFT = 9;

	// Download word 0 and word 2 of the image read through two views
	typedef union packed {
		struct packed {
			logic [7:0] rom_type;
			logic [3:0] ram_size;
			logic [3:0] rom_size;
		} size;
		struct packed {
			logic [6:0] rsvd_hi;
			logic       region;
			logic [7:0] rsvd_lo;
		} region;
	} hdr_word_u;

endpackage

`default_nettype wire

/* cart_header_detect.sv */
/*
 * ROM layout detection from the cartridge header
 * Reports ROM type, ROM and RAM address masks and the video region
 */
`default_nettype none

module cart_header_detect (
	input  logic                                clk_sys,
	input  logic                                cart_download,
	input  logic                                ioctl_wr,
	input  logic [snes_cart_pkg::IOCTL_AW-1:0]  ioctl_addr,
	input  logic [snes_cart_pkg::IOCTL_DW-1:0]  ioctl_dout,
	input  logic [2:0]                          lhrom_type,
	input  logic [1:0]                          region_sel,
	output logic [7:0]                          rom_type,
	output logic [snes_cart_pkg::MASK_W-1:0]    rom_mask,
	output logic [snes_cart_pkg::MASK_W-1:0]    ram_mask,
	output logic                                pal
);
	import snes_cart_pkg::*;

	hdr_word_u          hdr_word;
	logic [3:0]         rom_size;
	logic [3:0]         ram_size;
	logic [3:0]         rom_size_nxt;
	logic [3:0]         ram_size_nxt;
	logic               rom_region;
	logic               forced;
	logic [IOCTL_AW-1:0] info_addr;
	logic               hdr_wr;

	function automatic logic [MASK_W-1:0] size_to_mask(input logic [3:0] size_code);
		logic [MASK_W-1:0] unit;
		unit = MASK_W'(SIZE_UNIT);
		return (unit << size_code) - 1'b1;
	endfunction

	assign hdr_word = ioctl_dout;
	assign hdr_wr   = cart_download && ioctl_wr;

	// Info word location for the forced layouts
	always_comb begin
		forced = 1'b1;
		case (lhrom_type)
			ROM_LAYOUT_LO:   info_addr = LOROM_INFO + HDR_SKIP;
			ROM_LAYOUT_HI:   info_addr = HIROM_INFO + HDR_SKIP;
			ROM_LAYOUT_EXHI: info_addr = EXHIROM_INFO + HDR_SKIP;
			default: begin
				info_addr = '0;
				forced    = 1'b0;
			end
		endcase
	end

	// =========================================================================
	// Size codes for the current write
	// =========================================================================
	always_comb begin
		rom_size_nxt = rom_size;
		ram_size_nxt = ram_size;
		if (hdr_wr) begin
			if (ioctl_addr == '0) begin
				rom_size_nxt = DEF_ROM_SIZE;
				ram_size_nxt = DEF_RAM_SIZE;
				// Auto mode trusts word 0 when its low byte is set
				if (lhrom_type == ROM_LAYOUT_AUTO &&
				    {hdr_word.size.ram_size, hdr_word.size.rom_size} != 8'd0) begin
					rom_size_nxt = hdr_word.size.rom_size;
					ram_size_nxt = hdr_word.size.ram_size;
				end
			end
			if (forced && ioctl_addr == info_addr) begin
				rom_size_nxt = ioctl_dout[11:8];
			end
			if (forced && ioctl_addr == info_addr + IOCTL_AW'(2)) begin
				ram_size_nxt = ioctl_dout[3:0];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			rom_size <= rom_size_nxt;
			ram_size <= ram_size_nxt;
			rom_mask <= size_to_mask(rom_size_nxt);
			ram_mask <= (ram_size_nxt != 4'd0) ? size_to_mask(ram_size_nxt) : '0;
			if (ioctl_addr == '0) begin
				case (lhrom_type)
					ROM_LAYOUT_NONE: rom_type <= 8'd0;
					ROM_LAYOUT_LO:   rom_type <= 8'd0;
					ROM_LAYOUT_HI:   rom_type <= 8'd1;
					ROM_LAYOUT_EXHI: rom_type <= 8'd2;
					default:         rom_type <= hdr_word.size.rom_type;
				endcase
			end
			if (ioctl_addr == IOCTL_AW'(2)) begin
				rom_region <= hdr_word.region.region;
			end
		end
		// Region held while the image streams in
		if (!cart_download) begin
			pal <= (region_sel == 2'd0) ? rom_region : region_sel[1];
		end
	end

endmodule

`default_nettype wire

/* cheat_code_loader.sv */
/*
 * Cheat code record assembly from the code download, one strobe per record
 */
`default_nettype none

module cheat_code_loader (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               code_download,
	input  logic                               ioctl_wr,
	input  logic [3:0]                         ioctl_addr,
	input  logic [snes_cart_pkg::IOCTL_DW-1:0] ioctl_dout,
	output logic [snes_cart_pkg::GG_W-1:0]     gg_code,
	output logic                               gg_strobe
);
	import snes_cart_pkg::*;

	logic       code_wr;
	logic [2:0] slot;

	// Record layout, upper to lower
	//   flags 127:96, address 95:64, compare 63:32, replace 31:0
	// Each field arrives low half first, fields in that same order
	assign code_wr = code_download && ioctl_wr && !ioctl_addr[0];

	// Field order reversed against the offset, half from bit 1
	assign slot = {~ioctl_addr[3:2], ioctl_addr[1]};

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			gg_code[slot * IOCTL_DW +: IOCTL_DW] <= ioctl_dout;
		end
	end

	// Replace high half closes the record
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_strobe <= 1'b0;
		end else begin
			gg_strobe <= code_wr && (ioctl_addr == 4'd14);
		end
	end

endmodule

`default_nettype wire

/* backup_ram_sync.sv */
/*
 * Backup RAM enable, pending-write flag and the sector load/save
 * sequencer towards the host storage
 */
`default_nettype none

module backup_ram_sync (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             cart_download,
	input  logic [snes_cart_pkg::MASK_W-1:0] ram_mask,
	input  logic                             img_mounted,
	input  logic                             img_readonly,
	input  logic [63:0]                      img_size,
	input  logic                             bk_load_req,
	input  logic                             bk_save_req,
	input  logic                             autosave,
	input  logic                             osd_status,
	input  logic                             bsram_write,
	input  logic                             sd_ack,
	output logic [snes_cart_pkg::LBA_W-1:0]  sd_lba,
	output logic                             sd_rd,
	output logic                             sd_wr,
	output logic                             bk_loading,
	output logic                             bk_busy,
	output logic                             bk_pending
);
	import snes_cart_pkg::*;

	logic             bk_ena;
	logic             old_download;
	logic             old_load;
	logic             old_save;
	logic             old_ack;
	logic             load_lvl;
	logic             save_lvl;
	logic             load_edge;
	logic             save_edge;
	logic             download_end;
	logic             ack_rise;
	logic             ack_fall;
	logic [LBA_W-1:0] sector_last;

	// Last sector index taken from the RAM size
	assign sector_last = LBA_W'(ram_mask[MASK_W-1:SECTOR_SHIFT]);

	assign load_lvl  = bk_load_req && bk_ena;
	assign save_lvl  = (bk_save_req || (bk_pending && osd_status && autosave)) && bk_ena;
	assign load_edge = load_lvl && !old_load;
	assign save_edge = save_lvl && !old_save;

	assign download_end = old_download && !cart_download && (|img_size) && bk_ena;
	assign ack_rise     = sd_ack && !old_ack;
	assign ack_fall     = old_ack && !sd_ack;

	// =========================================================================
	// Enable and pending write
	// =========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (cart_download && !old_download) begin
				bk_ena <= 1'b0;
			end
			// Save image is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly) begin
				bk_ena <= |ram_mask;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_pending <= 1'b0;
		end else if (bk_ena && !osd_status && bsram_write) begin
			bk_pending <= 1'b1;
		end else if (bk_busy) begin
			bk_pending <= 1'b0;
		end
	end

	// =========================================================================
	// Sector sequencer
	// =========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_busy    <= 1'b0;
			bk_loading <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
		end else begin
			old_load <= load_lvl;
			old_save <= save_lvl;
			old_ack  <= sd_ack;

			// Host took the request
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_busy) begin
				if (load_edge || save_edge) begin
					bk_busy    <= 1'b1;
					bk_loading <= load_edge;
					sd_lba     <= '0;
					sd_rd      <= load_edge;
					sd_wr      <= !load_edge;
				end
				// Fresh cartridge always pulls its save in
				if (download_end) begin
					bk_busy    <= 1'b1;
					bk_loading <= 1'b1;
					sd_lba     <= '0;
					sd_rd      <= 1'b1;
					sd_wr      <= 1'b0;
				end
			end else if (ack_fall) begin
				if (sd_lba >= sector_last) begin
					bk_busy    <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* snes_cart_front.sv */
/*
 * Cartridge front end top level: download split, header detect,
 * cheat loader, backup RAM sync and core reset
 */
`default_nettype none

module snes_cart_front (
	input  logic                               clk_sys,
	input  logic                               reset,
	input  logic                               ioctl_download,
	input  logic [7:0]                         ioctl_index,
	input  logic [snes_cart_pkg::IOCTL_AW-1:0] ioctl_addr,
	input  logic [snes_cart_pkg::IOCTL_DW-1:0] ioctl_dout,
	input  logic                               ioctl_wr,
	input  logic [2:0]                         lhrom_type,
	input  logic [1:0]                         region_sel,
	input  logic                               bk_load_req,
	input  logic                               bk_save_req,
	input  logic                               autosave,
	input  logic                               osd_status,
	input  logic                               img_mounted,
	input  logic                               img_readonly,
	input  logic [63:0]                        img_size,
	input  logic                               bsram_write,
	input  logic                               sd_ack,
	output logic [7:0]                         rom_type,
	output logic [snes_cart_pkg::MASK_W-1:0]   rom_mask,
	output logic [snes_cart_pkg::MASK_W-1:0]   ram_mask,
	output logic                               pal,
	output logic [snes_cart_pkg::GG_W-1:0]     gg_code,
	output logic                               gg_strobe,
	output logic                               gg_reset,
	output logic [snes_cart_pkg::LBA_W-1:0]    sd_lba,
	output logic                               sd_rd,
	output logic                               sd_wr,
	output logic                               bk_busy,
	output logic                               bk_pending,
	output logic                               core_reset
);
	import snes_cart_pkg::*;

	logic code_download;
	logic cart_download;
	logic bk_loading;

	// Cheat files use the reserved index, everything else is the cartridge
	assign code_download = ioctl_download && (ioctl_index == CODE_INDEX);
	assign cart_download = ioctl_download && (ioctl_index != CODE_INDEX);

	// Cheat list restarts with a new cartridge or a new code file
	assign gg_reset = cart_download || (code_download && ioctl_wr && ioctl_addr == '0);

	// Core held while the image or its save streams in
	assign core_reset = reset || cart_download || bk_loading;

	cart_header_detect u_header (
		.clk_sys       (clk_sys),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.lhrom_type    (lhrom_type),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	cheat_code_loader u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr[3:0]),
		.ioctl_dout    (ioctl_dout),
		.gg_code       (gg_code),
		.gg_strobe     (gg_strobe)
	);

	backup_ram_sync u_backup (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ram_mask      (ram_mask),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_size      (img_size),
		.bk_load_req   (bk_load_req),
		.bk_save_req   (bk_save_req),
		.autosave      (autosave),
		.osd_status    (osd_status),
		.bsram_write   (bsram_write),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.bk_loading    (bk_loading),
		.bk_busy       (bk_busy),
		.bk_pending    (bk_pending)
	);

endmodule

`default_nettype wire

/* tb_snes_cart_tasks.svh */
/*
 * Stimulus tasks: clock steps, download words, cheat records, transfer wait
 */
`ifndef TB_SNES_CART_TASKS_SVH
`define TB_SNES_CART_TASKS_SVH

// Lands 1 ns past the n-th rising edge
task automatic step_cycles(input int n);
	repeat (n) @(posedge clk_sys);
	#1;
endtask

task automatic start_download(input logic [7:0] index);
	ioctl_index    = index;
	ioctl_download = 1'b1;
	step_cycles(1);
endtask

// Idle download cycles first so the backup enable sees the new RAM mask
task automatic end_download();
	step_cycles(2);
	ioctl_download = 1'b0;
	step_cycles(1);
endtask

task automatic write_word(input logic [IOCTL_AW-1:0] addr, input logic [IOCTL_DW-1:0] data);
	ioctl_addr = addr;
	ioctl_dout = data;
	ioctl_wr   = 1'b1;
	step_cycles(1);
	ioctl_wr   = 1'b0;
endtask

// Eight LFSR words at even offsets, replace high half last
task automatic send_cheat_record(input logic [IOCTL_AW-1:0] base);
	logic [IOCTL_DW-1:0] words [8];
	for (int i = 0; i < 8; i++) begin
		words[i] = random_word();
	end
	for (int i = 0; i < 7; i++) begin
		write_word(base + IOCTL_AW'(2 * i), words[i]);
	end
	// Flags, address, compare, replace, high half above low half
	exp_code = {words[1], words[0], words[3], words[2],
		words[5], words[4], words[7], words[6]};
	write_word(base + IOCTL_AW'(14), words[7]);
	records_sent++;
endtask

task automatic wait_transfer_done();
	while (!bk_busy) begin
		step_cycles(1);
	end
	while (bk_busy) begin
		step_cycles(1);
	end
endtask

`endif

/* tb_snes_cart_front.sv */
/*
 * Testbench of the cartridge front end: clock, reset, DUT, storage host
 * model, LFSR stimulus, cycle limit and the assertions that check it all
 */
`default_nettype none

module tb_snes_cart_front;
	timeunit 1ns;
	timeprecision 100ps;
	import snes_cart_pkg::*;

	// Three downloads, one load and two saves of 16 sectors stay far below this
	localparam int CYCLE_LIMIT = 20000;

	logic                clk_sys;
	logic                reset;
	logic                ioctl_download;
	logic [7:0]          ioctl_index;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [IOCTL_DW-1:0] ioctl_dout;
	logic                ioctl_wr;
	logic [2:0]          lhrom_type;
	logic [1:0]          region_sel;
	logic                bk_load_req;
	logic                bk_save_req;
	logic                autosave;
	logic                osd_status;
	logic                img_mounted;
	logic                img_readonly;
	logic [63:0]         img_size;
	logic                bsram_write;
	logic                sd_ack;
	logic [7:0]          rom_type;
	logic [MASK_W-1:0]   rom_mask;
	logic [MASK_W-1:0]   ram_mask;
	logic                pal;
	logic [GG_W-1:0]     gg_code;
	logic                gg_strobe;
	logic                gg_reset;
	logic [LBA_W-1:0]    sd_lba;
	logic                sd_rd;
	logic                sd_wr;
	logic                bk_busy;
	logic                bk_pending;
	logic                core_reset;

	// Expected values and check enables
	logic [7:0]          exp_rom_type;
	logic [MASK_W-1:0]   exp_rom_mask;
	logic [MASK_W-1:0]   exp_ram_mask;
	logic [GG_W-1:0]     exp_code;
	logic                region_flag;
	logic                hdr_check;
	logic                pal_check;
	logic                expect_load;
	logic                backup_enabled;
	logic [15:0]         lfsr_state;
	logic                cart_dl;
	logic                code_dl;
	int                  rd_sectors = 0;
	int                  wr_sectors = 0;
	int                  records_sent = 0;
	int                  strobes_seen = 0;
	int                  cycles = 0;

	assign cart_dl = ioctl_download && (ioctl_index != CODE_INDEX);
	assign code_dl = ioctl_download && (ioctl_index == CODE_INDEX);

	snes_cart_front u_snes_cart_front (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test failed");
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [IOCTL_DW-1:0] random_word();
		logic [IOCTL_DW-1:0] w;
		w = '0;
		for (int i = 0; i < IOCTL_DW; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			w = {w[IOCTL_DW-2:0], lfsr_state[0]};
		end
		return w;
	endfunction

	// Size code n covers SIZE_UNIT << n bytes
	function automatic logic [MASK_W-1:0] mask_for_size(input logic [3:0] code);
		return MASK_W'((SIZE_UNIT << code) - 1);
	endfunction

	function automatic logic expected_pal(input logic [1:0] sel, input logic flag);
		return (sel == 2'd0) ? flag : sel[1];
	endfunction

	function automatic int sectors_expected();
		return int'(exp_ram_mask >> SECTOR_SHIFT) + 1;
	endfunction

	`include "tb_snes_cart_tasks.svh"

	// =========================================================================
	// Storage host model
	// =========================================================================
	initial begin : host_model
		logic             xfer_rd;
		logic [LBA_W-1:0] xfer_lba;
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd || sd_wr) begin
				xfer_rd  = sd_rd;
				xfer_lba = sd_lba;
				assert (xfer_lba == LBA_W'(xfer_rd ? rd_sectors : wr_sectors)) else begin
					report_failure($sformatf("ERR sd_lba got %h exp %h", xfer_lba,
						xfer_rd ? rd_sectors : wr_sectors));
					$fatal(1);
				end
				repeat (3) @(posedge clk_sys);
				#1 sd_ack = 1'b1;
				repeat (4) @(posedge clk_sys);
				#1 sd_ack = 1'b0;
				if (xfer_rd) begin
					rd_sectors++;
				end else begin
					wr_sectors++;
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		if (!reset && gg_strobe) begin
			strobes_seen <= strobes_seen + 1;
		end
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			report_failure($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
			$fatal(1);
		end
	end

	// =========================================================================
	// Assertions
	// =========================================================================
	assert property (@(posedge clk_sys) $fell(reset) |->
		!sd_rd && !sd_wr && !bk_busy && !bk_pending && !gg_strobe && !core_reset)
	else begin
		report_failure($sformatf("ERR reset state sd_rd %h sd_wr %h bk_busy %h exp 0",
			$sampled(sd_rd), $sampled(sd_wr), $sampled(bk_busy)));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		$past(cart_dl && ioctl_wr && ioctl_addr == '0) |-> rom_type == exp_rom_type)
	else begin
		report_failure($sformatf("ERR rom_type got %h exp %h", $sampled(rom_type),
			exp_rom_type));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		hdr_check |-> rom_mask == exp_rom_mask)
	else begin
		report_failure($sformatf("ERR rom_mask got %h exp %h", $sampled(rom_mask),
			exp_rom_mask));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		hdr_check |-> ram_mask == exp_ram_mask)
	else begin
		report_failure($sformatf("ERR ram_mask got %h exp %h", $sampled(ram_mask),
			exp_ram_mask));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		pal_check |-> pal == expected_pal($past(region_sel), region_flag))
	else begin
		report_failure($sformatf("ERR pal got %h exp %h", $sampled(pal),
			expected_pal($past(region_sel), region_flag)));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		gg_strobe |-> gg_code == exp_code)
	else begin
		report_failure($sformatf("ERR gg_code got %h exp %h", $sampled(gg_code), exp_code));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset) gg_strobe |=> !gg_strobe)
	else begin
		report_failure("gg_strobe stayed high for more than one cycle");
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		(cart_dl || (code_dl && ioctl_wr && ioctl_addr == '0)) |-> gg_reset)
	else begin
		report_failure($sformatf("ERR gg_reset got %h exp 1", $sampled(gg_reset)));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		(expect_load && bk_busy) |-> core_reset)
	else begin
		report_failure($sformatf("ERR core_reset got %h exp 1", $sampled(core_reset)));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		(!cart_dl && !bk_busy) |-> !core_reset)
	else begin
		report_failure($sformatf("ERR core_reset got %h exp 0", $sampled(core_reset)));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		(backup_enabled && bsram_write && !osd_status) |=> bk_pending)
	else begin
		report_failure($sformatf("ERR bk_pending got %h exp 1", $sampled(bk_pending)));
		$fatal(1);
	end

	assert property (@(posedge clk_sys) disable iff (reset)
		($rose(bk_busy) && !bsram_write) |=> !bk_pending)
	else begin
		report_failure($sformatf("ERR bk_pending got %h exp 0", $sampled(bk_pending)));
		$fatal(1);
	end

	// =========================================================================
	// Test sequence
	// =========================================================================
	initial begin
		hdr_word_u word0;
		hdr_word_u word2;
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		lhrom_type     = ROM_LAYOUT_AUTO;
		region_sel     = 2'd0;
		bk_load_req    = 1'b0;
		bk_save_req    = 1'b0;
		autosave       = 1'b0;
		osd_status     = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bsram_write    = 1'b0;
		exp_rom_type   = '0;
		exp_rom_mask   = '0;
		exp_ram_mask   = '0;
		exp_code       = '0;
		region_flag    = 1'b0;
		hdr_check      = 1'b0;
		pal_check      = 1'b0;
		expect_load    = 1'b0;
		backup_enabled = 1'b0;
		lfsr_state     = 16'd82;
		repeat (5) @(posedge clk_sys);
		#1 reset = 1'b0;
		step_cycles(2);

		// Forced HI layout, word 0 ignored, no save RAM
		lhrom_type   = ROM_LAYOUT_HI;
		exp_rom_type = 8'd1;
		exp_rom_mask = mask_for_size(4'hA);
		exp_ram_mask = '0;
		word2        = '0;
		start_download(8'h00);
		write_word('0, 16'h2155);
		write_word(IOCTL_AW'(2), word2);
		write_word(HIROM_INFO + HDR_SKIP, 16'h0A00);
		write_word(HIROM_INFO + HDR_SKIP + IOCTL_AW'(2), 16'h0000);
		end_download();
		hdr_check = 1'b1;
		step_cycles(3);

		// Three cheat records back to back
		start_download(CODE_INDEX);
		for (int r = 0; r < 3; r++) begin
			send_cheat_record(IOCTL_AW'(16 * r));
		end
		end_download();
		step_cycles(3);

		// AUTO layout with a writable save image, load follows
		hdr_check              = 1'b0;
		lhrom_type             = ROM_LAYOUT_AUTO;
		word0.size.rom_type    = 8'h21;
		word0.size.ram_size    = 4'h3;
		word0.size.rom_size    = 4'hB;
		word2                  = '0;
		word2.region.region    = 1'b1;
		exp_rom_type           = 8'h21;
		exp_rom_mask           = mask_for_size(4'hB);
		exp_ram_mask           = mask_for_size(4'h3);
		region_flag            = 1'b1;
		img_mounted            = 1'b1;
		img_size               = 64'h2000;
		rd_sectors             = 0;
		expect_load            = 1'b1;
		start_download(8'h01);
		write_word('0, word0);
		write_word(IOCTL_AW'(2), word2);
		end_download();
		hdr_check = 1'b1;
		pal_check = 1'b1;
		wait_transfer_done();
		assert (rd_sectors == sectors_expected()) else begin
			report_failure($sformatf("ERR rd_sectors got %h exp %h", rd_sectors,
				sectors_expected()));
			$fatal(1);
		end
		expect_load    = 1'b0;
		backup_enabled = 1'b1;

		// Region forced from the menu
		region_sel = 2'd1;
		step_cycles(3);
		region_sel = 2'd3;
		step_cycles(3);
		region_sel = 2'd0;
		step_cycles(3);

		// Core write, then autosave when the menu opens
		bsram_write = 1'b1;
		step_cycles(1);
		bsram_write = 1'b0;
		step_cycles(2);
		wr_sectors = 0;
		autosave   = 1'b1;
		osd_status = 1'b1;
		wait_transfer_done();
		assert (wr_sectors == sectors_expected()) else begin
			report_failure($sformatf("ERR wr_sectors got %h exp %h", wr_sectors,
				sectors_expected()));
			$fatal(1);
		end

		// Save on request from idle
		osd_status = 1'b0;
		autosave   = 1'b0;
		step_cycles(2);
		wr_sectors  = 0;
		bk_save_req = 1'b1;
		step_cycles(1);
		bk_save_req = 1'b0;
		wait_transfer_done();
		assert (wr_sectors == sectors_expected()) else begin
			report_failure($sformatf("ERR wr_sectors got %h exp %h", wr_sectors,
				sectors_expected()));
			$fatal(1);
		end

		step_cycles(5);
		assert (strobes_seen == records_sent) else begin
			report_failure($sformatf("ERR gg_strobe count got %h exp %h", strobes_seen,
				records_sent));
			$fatal(1);
		end
		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* snes_cart_front.f */
+incdir+.
snes_cart_pkg.sv
cart_header_detect.sv
cheat_code_loader.sv
backup_ram_sync.sv
snes_cart_front.sv
tb_snes_cart_front.sv
